// File: source/ooo_pkg.sv
package ooo_pkg;

    localparam int data_w     = 32;               // Operand and result width
    localparam int rob_depth  = 16;               // ROB entries
    localparam int tag_w      = 4;                // ROB index width
    localparam int num_lanes  = 3;                // Execution lanes
    localparam int mul_cycles = 4;                // Multiply iterations, 8 bits each

    typedef logic [data_w-1:0]    word_t;         // Operand or result
    typedef logic [tag_w-1:0]     tag_t;          // ROB index
    typedef logic [4:0]           reg_idx_t;      // Architectural register
    typedef logic [num_lanes-1:0] lane_mask_t;    // One bit per lane

    // Operation codes carried with each instruction
    typedef enum logic [2:0] {
        ADD = 3'd0,                               // a + b
        SUB = 3'd1,                               // a - b
        XOR = 3'd2,                               // a ^ b
        SHL = 3'd3,                               // a << b[4:0]
        MUL = 3'd4                                // Low 32 bits of a * b
    } op_e;

    // Execution lane FSM
    typedef enum logic [1:0] {
        IDLE   = 2'd0,                            // Free for new work
        ACK    = 2'd1,                            // Fields latched, ack high
        BUSY   = 2'd2,                            // Computing
        REPORT = 2'd3                             // Result offered to arbiter
    } lane_state_e;

endpackage

// File: source/dispatch.sv
`timescale 1ns/1ps

module dispatch (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instr_req,
    input  ooo_pkg::op_e         instr_op,
    input  ooo_pkg::word_t       instr_a,
    input  ooo_pkg::word_t       instr_b,
    input  ooo_pkg::reg_idx_t    instr_dest,
    input  logic                 instr_reg_write,
    output logic                 instr_ack,
    input  logic                 rob_full,
    input  ooo_pkg::tag_t        alloc_tag,
    output logic                 alloc,
    output ooo_pkg::reg_idx_t    alloc_dest,
    output logic                 alloc_reg_write,
    input  ooo_pkg::lane_mask_t  lane_idle,
    input  ooo_pkg::lane_mask_t  lane_ack,
    output ooo_pkg::lane_mask_t  lane_req,
    output ooo_pkg::op_e         lane_op,
    output ooo_pkg::word_t       lane_a,
    output ooo_pkg::word_t       lane_b,
    output ooo_pkg::tag_t        lane_tag
);
    import ooo_pkg::*;

    typedef enum logic [1:0] {
        S_WAIT      = 2'd0,                       // Waiting for req, ROB space, idle lane
        S_LANE_REQ  = 2'd1,                       // lane_req high until lane acks
        S_LANE_REL  = 2'd2,                       // lane_req low until lane ack drops
        S_INSTR_ACK = 2'd3                        // instr_ack high until source releases
    } disp_state_e;

    disp_state_e state;
    lane_mask_t  lane_sel;                        // One-hot chosen lane
    lane_mask_t  pick;                            // Lowest idle lane, one-hot

    // Priority pick, lowest index wins
    always_comb begin
        pick = '0;
        for (int i = num_lanes - 1; i >= 0; i--) begin
            if (lane_idle[i]) pick = lane_mask_t'(1) << i;
        end
    end

    assign alloc           = (state == S_WAIT) && instr_req && !rob_full && (|lane_idle);
    assign alloc_dest      = instr_dest;          // Written into ROB at the tail
    assign alloc_reg_write = instr_reg_write;
    assign lane_req        = (state == S_LANE_REQ) ? lane_sel : '0;
    assign instr_ack       = (state == S_INSTR_ACK);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= S_WAIT;
            lane_sel <= '0;
        end else begin
            case (state)
                S_WAIT: if (alloc) begin
                    lane_sel <= pick;             // Lock the lane for this handshake
                    state    <= S_LANE_REQ;
                end
                S_LANE_REQ:  if (|(lane_ack & lane_sel)) state <= S_LANE_REL;
                S_LANE_REL:  if (!(|(lane_ack & lane_sel))) state <= S_INSTR_ACK;
                S_INSTR_ACK: if (!instr_req) state <= S_WAIT;
                default:     state <= S_WAIT;
            endcase
        end
    end

    // Work fields held on the shared lane buses until the next allocation
    always_ff @(posedge clk) begin
        if (alloc) begin
            lane_op  <= instr_op;
            lane_a   <= instr_a;
            lane_b   <= instr_b;
            lane_tag <= alloc_tag;                // Current ROB tail
        end
    end

endmodule

// File: source/exec_lane.sv
`timescale 1ns/1ps

module exec_lane (
    input  logic            clk,
    input  logic            rst,
    input  logic            lane_req,
    input  ooo_pkg::op_e    lane_op,
    input  ooo_pkg::word_t  lane_a,
    input  ooo_pkg::word_t  lane_b,
    input  ooo_pkg::tag_t   lane_tag,
    output logic            lane_ack,
    output logic            lane_idle,
    output logic            done_req,
    input  logic            done_ack,
    output ooo_pkg::word_t  done_value,
    output ooo_pkg::tag_t   done_tag
);
    import ooo_pkg::*;

    lane_state_e                     state;
    logic [$clog2(mul_cycles)-1:0]   cnt;         // Multiply iteration
    op_e                             cur_op;
    word_t                           opnd_a;      // Multiplicand, shifts left
    word_t                           opnd_b;      // Multiplier, shifts right
    word_t                           acc;         // Result accumulator
    word_t                           alu_res;
    tag_t                            cur_tag;

    always_comb begin
        case (cur_op)
            ADD:     alu_res = opnd_a + opnd_b;
            SUB:     alu_res = opnd_a - opnd_b;
            XOR:     alu_res = opnd_a ^ opnd_b;
            SHL:     alu_res = opnd_a << opnd_b[4:0];  // Low 5 bits only
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: if (lane_req) state <= ACK;
                ACK: if (!lane_req) begin         // Req released, start work
                    state <= BUSY;
                    cnt   <= '0;
                end
                BUSY: begin
                    cnt <= cnt + 1'b1;
                    if (cur_op != MUL || cnt == (mul_cycles - 1)) state <= REPORT;
                end
                REPORT: if (done_ack) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: if (lane_req) begin
                cur_op  <= lane_op;
                opnd_a  <= lane_a;
                opnd_b  <= lane_b;
                cur_tag <= lane_tag;
            end
            ACK: acc <= '0;
            BUSY: if (cur_op == MUL) begin
                acc    <= acc + opnd_a * word_t'(opnd_b[7:0]);  // 8-bit partial product
                opnd_a <= opnd_a << 8;
                opnd_b <= opnd_b >> 8;
            end else begin
                acc <= alu_res;
            end
            default: ;                            // Hold result through REPORT
        endcase
    end

    assign lane_idle  = (state == IDLE);
    assign lane_ack   = (state == ACK);
    assign done_req   = (state == REPORT);
    assign done_value = acc;
    assign done_tag   = cur_tag;

endmodule

// File: source/completion_arbiter.sv
`timescale 1ns/1ps

module completion_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    input  ooo_pkg::lane_mask_t  done_req,
    input  ooo_pkg::word_t       done_value [ooo_pkg::num_lanes],
    input  ooo_pkg::tag_t        done_tag [ooo_pkg::num_lanes],
    output ooo_pkg::lane_mask_t  done_ack,
    output logic                 cmpl_valid,
    output ooo_pkg::word_t       cmpl_value,
    output ooo_pkg::tag_t        cmpl_tag
);
    import ooo_pkg::*;

    typedef logic [$clog2(num_lanes)-1:0] lane_idx_t;

    lane_idx_t   rr_ptr;                          // Lane checked first
    lane_idx_t   grant_idx;
    logic        grant_found;
    lane_mask_t  eligible;                        // Requesting and not yet acked

    assign eligible = done_req & ~done_ack;

    // Rotating search from rr_ptr
    always_comb begin
        grant_found = 1'b0;
        grant_idx   = '0;
        for (int k = 0; k < num_lanes; k++) begin
            if (!grant_found && eligible[(int'(rr_ptr) + k) % num_lanes]) begin
                grant_found = 1'b1;
                grant_idx   = lane_idx_t'((int'(rr_ptr) + k) % num_lanes);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rr_ptr     <= '0;
            done_ack   <= '0;
            cmpl_valid <= 1'b0;
        end else begin
            cmpl_valid <= grant_found;            // One strobe per cycle at most
            done_ack   <= (done_ack & done_req) |
                          (grant_found ? lane_mask_t'(1) << grant_idx : '0);
            if (grant_found) begin
                rr_ptr <= (int'(grant_idx) == num_lanes - 1) ? '0 : grant_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_found) begin
            cmpl_value <= done_value[grant_idx];
            cmpl_tag   <= done_tag[grant_idx];
        end
    end

endmodule

// File: source/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc,
    input  ooo_pkg::reg_idx_t  alloc_dest,
    input  logic               alloc_reg_write,
    output ooo_pkg::tag_t      alloc_tag,
    output logic               rob_full,
    input  logic               cmpl_valid,
    input  ooo_pkg::tag_t      cmpl_tag,
    input  ooo_pkg::word_t     cmpl_value,
    output logic               commit_req,
    input  logic               commit_ack,
    output ooo_pkg::word_t     commit_value,
    output ooo_pkg::reg_idx_t  commit_dest,
    output logic               commit_reg_write
);
    import ooo_pkg::*;

    logic      ent_ready [rob_depth];             // Result written back
    logic      ent_reg_write [rob_depth];
    reg_idx_t  ent_dest [rob_depth];
    word_t     ent_value [rob_depth];

    tag_t              head;                      // Oldest entry
    tag_t              tail;                      // Next free entry
    logic [tag_w:0]    count;                     // Occupancy, 0 to rob_depth
    logic              present;                   // Head can be offered now
    logic              retire;                    // Head leaves this cycle

    assign alloc_tag = tail;
    assign rob_full  = (count == (tag_w + 1)'(rob_depth));

    // Only offer a new head once the previous ack has fallen
    assign present = !commit_req && !commit_ack && (count != '0) && ent_ready[head];
    assign retire  = commit_req && commit_ack;

    // Pointers, occupancy and the commit handshake
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            commit_req <= 1'b0;
        end else begin
            if (alloc) tail <= tail + 1'b1;       // Wraps at rob_depth
            if (retire) head <= head + 1'b1;
            case ({alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // Both or neither
            endcase
            if (present) begin
                commit_req <= 1'b1;
            end else if (retire) begin
                commit_req <= 1'b0;               // Head freed on ack
            end
        end
    end

    // Ready flags, cleared on allocate and set on completion
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < rob_depth; i++) begin
                ent_ready[i] <= 1'b0;
            end
        end else begin
            if (alloc) ent_ready[tail] <= 1'b0;
            if (cmpl_valid) ent_ready[cmpl_tag] <= 1'b1;  // Never the tail slot
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (alloc) begin
            ent_dest[tail]      <= alloc_dest;
            ent_reg_write[tail] <= alloc_reg_write;
        end
        if (cmpl_valid) ent_value[cmpl_tag] <= cmpl_value;
    end

    // Commit fields held while commit_req is high
    always_ff @(posedge clk) begin
        if (present) begin
            commit_value     <= ent_value[head];
            commit_dest      <= ent_dest[head];
            commit_reg_write <= ent_reg_write[head];
        end
    end

endmodule

// File: source/ooo_core.sv
`timescale 1ns/1ps

module ooo_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_req,
    input  ooo_pkg::op_e       instr_op,
    input  ooo_pkg::word_t     instr_a,
    input  ooo_pkg::word_t     instr_b,
    input  ooo_pkg::reg_idx_t  instr_dest,
    input  logic               instr_reg_write,
    output logic               instr_ack,
    output logic               commit_req,
    input  logic               commit_ack,
    output ooo_pkg::word_t     commit_value,
    output ooo_pkg::reg_idx_t  commit_dest,
    output logic               commit_reg_write
);
    import ooo_pkg::*;

    // Dispatch and ROB allocation
    logic        alloc;
    reg_idx_t    alloc_dest;
    logic        alloc_reg_write;
    tag_t        alloc_tag;
    logic        rob_full;

    // Shared lane buses and per-lane handshakes
    lane_mask_t  lane_req;
    lane_mask_t  lane_ack;
    lane_mask_t  lane_idle;
    op_e         lane_op;
    word_t       lane_a;
    word_t       lane_b;
    tag_t        lane_tag;

    // Lane results toward the arbiter
    lane_mask_t  done_req;
    lane_mask_t  done_ack;
    word_t       done_value [num_lanes];
    tag_t        done_tag [num_lanes];

    // Completion strobe into the ROB
    logic        cmpl_valid;
    word_t       cmpl_value;
    tag_t        cmpl_tag;

    dispatch dispatch_inst (
        .clk, .rst, .instr_req, .instr_op, .instr_a, .instr_b, .instr_dest,
        .instr_reg_write, .instr_ack, .rob_full, .alloc_tag, .alloc, .alloc_dest,
        .alloc_reg_write, .lane_idle, .lane_ack, .lane_req, .lane_op, .lane_a,
        .lane_b, .lane_tag
    );

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        exec_lane exec_lane_inst (
            .clk, .rst, .lane_req(lane_req[i]), .lane_op, .lane_a, .lane_b,
            .lane_tag, .lane_ack(lane_ack[i]), .lane_idle(lane_idle[i]),
            .done_req(done_req[i]), .done_ack(done_ack[i]),
            .done_value(done_value[i]), .done_tag(done_tag[i])
        );
    end

    completion_arbiter completion_arbiter_inst (
        .clk, .rst, .done_req, .done_value, .done_tag, .done_ack,
        .cmpl_valid, .cmpl_value, .cmpl_tag
    );

    reorder_buffer reorder_buffer_inst (
        .clk, .rst, .alloc, .alloc_dest, .alloc_reg_write, .alloc_tag, .rob_full,
        .cmpl_valid, .cmpl_tag, .cmpl_value, .commit_req, .commit_ack,
        .commit_value, .commit_dest, .commit_reg_write
    );

endmodule

// File: sim/tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int n_directed  = 17;               // Edge operands, ordering, no-write cases
    localparam int n_fill      = 40;               // ROB fill phase
    localparam int n_random    = 200;
    localparam int num_instr   = n_directed + n_fill + n_random;
    localparam int cycle_limit = 20 * num_instr + 200;

    typedef struct packed {
        logic     rw;
        reg_idx_t dest;
        word_t    value;
    } exp_t;

    logic     clk;
    logic     rst;
    logic     instr_req;
    op_e      instr_op;
    word_t    instr_a;
    word_t    instr_b;
    reg_idx_t instr_dest;
    logic     instr_reg_write;
    logic     instr_ack;
    logic     commit_req;
    logic     commit_ack;
    word_t    commit_value;
    reg_idx_t commit_dest;
    logic     commit_reg_write;

    exp_t exp_q[$];                                // Expected commits in program order
    int   errors = 0;
    int   commits = 0;
    int   cycles = 0;
    logic hold_commit = 1'b0;                      // Withhold commit_ack while set

    ooo_core ooo_core_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                    // 40 ns period
    end

    function automatic word_t compute_result(input op_e op, input word_t a, input word_t b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            XOR:     return a ^ b;
            SHL:     return a << b[4:0];           // Amount from low 5 bits
            default: return a * b;                 // MUL, low 32 bits
        endcase
    endfunction

    // Biased toward 0 and all ones
    function automatic word_t pick_operand();
        case ($urandom_range(3, 0))
            0:       return '0;
            1:       return '1;
            default: return $urandom;
        endcase
    endfunction

    // Four-phase input transfer, entered and left 2 ns after a rising edge
    task automatic send(input op_e op, input word_t a, input word_t b,
                        input reg_idx_t dest, input logic rw);
        instr_op        = op;
        instr_a         = a;
        instr_b         = b;
        instr_dest      = dest;
        instr_reg_write = rw;
        instr_req       = 1'b1;
        do @(posedge clk); while (!instr_ack);
        exp_q.push_back({rw, dest, compute_result(op, a, b)});
        #2 instr_req = 1'b0;
        do @(posedge clk); while (instr_ack);     // Fields free once ack is low
        #2;
    endtask

    task automatic send_random();
        send(op_e'($urandom_range(4, 0)), pick_operand(), pick_operand(),
             reg_idx_t'($urandom), 1'($urandom));
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0 || commit_ack) @(posedge clk);
        #2;
    endtask

    // Commit side: random ack delay, head checked against the queue
    initial begin : commit_side
        exp_t head_exp;
        commit_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (commit_req && !hold_commit) begin
                repeat ($urandom_range(6, 0)) @(posedge clk);
                if (exp_q.size() == 0) begin
                    $display("A commit arrived with no instruction outstanding");
                    errors++;
                end else begin
                    head_exp = exp_q.pop_front();
                    if (commit_value !== head_exp.value) begin
                        $display("ERROR commit_value expected %h got %h",
                                 head_exp.value, commit_value);
                        errors++;
                    end
                    if (commit_dest !== head_exp.dest) begin
                        $display("ERROR commit_dest expected %h got %h",
                                 head_exp.dest, commit_dest);
                        errors++;
                    end
                    if (commit_reg_write !== head_exp.rw) begin
                        $display("ERROR commit_reg_write expected %h got %h",
                                 head_exp.rw, commit_reg_write);
                        errors++;
                    end
                end
                commits++;
                #2 commit_ack = 1'b1;
                do @(posedge clk); while (commit_req);  // ROB retires, req falls
                #2 commit_ack = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("The run timed out after %0d cycles with %0d commits", cycles, commits);
            $display("Errors: %0d", errors + 1);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(25));
        rst             = 1'b1;
        instr_req       = 1'b0;
        instr_op        = ADD;
        instr_a         = '0;
        instr_b         = '0;
        instr_dest      = '0;
        instr_reg_write = 1'b0;
        repeat (8) @(posedge clk);
        #2 rst = 1'b0;
        repeat (10) @(posedge clk);                // Idle, nothing may commit
        if (commit_req !== 1'b0) begin
            $display("ERROR commit_req expected 0 got %h", commit_req);
            errors++;
        end
        if (instr_ack !== 1'b0) begin
            $display("ERROR instr_ack expected 0 got %h", instr_ack);
            errors++;
        end
        if (commits != 0) begin
            $display("Something committed before any instruction was sent");
            errors++;
        end
        #2;
        send(ADD, 32'h0, 32'h0, 5'd1, 1'b1);
        send(ADD, 32'hffff_ffff, 32'h1, 5'd2, 1'b1);    // Wraps to 0
        send(SUB, 32'h0, 32'h1, 5'd3, 1'b1);
        send(SUB, 32'h5, 32'hffff_ffff, 5'd4, 1'b1);
        send(XOR, 32'hffff_ffff, 32'ha5a5_a5a5, 5'd5, 1'b1);
        send(SHL, 32'h1, 32'd31, 5'd6, 1'b1);
        send(SHL, 32'hffff_ffff, 32'd32, 5'd7, 1'b1);    // Amount 0
        send(SHL, 32'h3, 32'd63, 5'd8, 1'b1);
        send(MUL, 32'hffff_ffff, 32'hffff_ffff, 5'd9, 1'b1);
        send(MUL, 32'h0, 32'h1234_5678, 5'd10, 1'b1);
        send(MUL, 32'h0001_2345, 32'h0000_6789, 5'd11, 1'b1);
        send(MUL, 32'hdead_beef, 32'h0bad_cafe, 5'd12, 1'b1);  // Slow one first
        send(ADD, 32'h10, 32'h20, 5'd13, 1'b1);
        send(XOR, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 5'd14, 1'b1);
        send(SUB, 32'h100, 32'h1, 5'd15, 1'b1);
        send(ADD, 32'h7, 32'h8, 5'd16, 1'b0);            // No register write
        send(MUL, 32'h3, 32'h5, 5'd17, 1'b0);
        wait_drained();
        hold_commit = 1'b1;                        // Retirement stalls, ROB fills
        fork
            repeat (n_fill) send_random();
            begin
                while (exp_q.size() < rob_depth) @(posedge clk);
                repeat (2) @(posedge clk);         // Last instr_ack falls
                repeat (30) begin
                    @(posedge clk);
                    if (instr_ack !== 1'b0) begin
                        $display("ERROR instr_ack expected 0 got %h", instr_ack);
                        errors++;
                    end
                end
                #2 hold_commit = 1'b0;
            end
        join
        repeat (n_random) send_random();
        repeat (400) begin
            if (exp_q.size() == 0 && !commit_ack) break;
            @(posedge clk);
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected commits never arrived", exp_q.size());
            errors++;
        end
        if (commits != num_instr) begin
            $display("Sent %0d instructions but saw %0d commits", num_instr, commits);
            errors++;
        end
        $display("Commits: %0d, errors: %0d", commits, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
source/ooo_pkg.sv
source/dispatch.sv
source/exec_lane.sv
source/completion_arbiter.sv
source/reorder_buffer.sv
source/ooo_core.sv
sim/tb_ooo_core.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build tb_ooo_core with Verilator, run it and check for the pass message"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -Wno-fatal -f src.f --top-module tb_ooo_core -o tb_ooo_core
	@out="$$(./obj_dir/tb_ooo_core)"; echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
